//--- verilog/zport_map_pkg.sv
// port map of the z80 i/o block
// low-byte port numbers and the two views of the address word
package zport_map_pkg;

	////////////////////////////////////////////////////////////////////////////
	// low byte of the port address

	localparam logic [7:0] port_fe   = 8'hFE; // border out, keys and tape in
	localparam logic [7:0] port_fd   = 8'hFD; // 7ffd paging
	localparam logic [7:0] port_f7   = 8'hF7; // eff7 paging, a8 moves in shadow
	localparam logic [7:0] port_bf   = 8'hBF; // config port
	localparam logic [7:0] port_be   = 8'hBE; // config read-back, nmi end
	localparam logic [7:0] port_kjoy = 8'h1F; // kempston joystick
	localparam logic [7:0] port_sav1 = 8'h2F; // save ports, shadow only
	localparam logic [7:0] port_sav2 = 8'h4F;
	localparam logic [7:0] port_sav3 = 8'h6F;
	localparam logic [7:0] port_sav4 = 8'h8F;

	// xxBE read-back index in a[11:8]
	localparam logic [3:0] be_idx_7ffd = 4'hA;
	localparam logic [3:0] be_idx_eff7 = 4'hB;

	localparam int sav_idx_w = 2; // four save ports

	////////////////////////////////////////////////////////////////////////////
	// z80 address, seen as two bytes or as the bits the decoder looks at

	typedef union packed
	{
		struct packed
		{
			logic [7:0] hi;
			logic [7:0] lo; // port number
		} bytes;
		struct packed
		{
			logic                 a15;     // 7ffd qualifier
			logic                 a14;
			logic                 a13;
			logic                 a12;     // eff7 qualifier
			logic [3:0]           be_idx;  // a[11:8], bit 0 is a8
			logic                 a7;
			logic [sav_idx_w-1:0] sav_idx; // a[6:5] picks the save port
			logic [4:0]           a4_0;
		} sel;
	} zaddr_u;

endpackage

//--- verilog/zport_cfg_pkg.sv
// register layout of the paging and config ports
// reset values and bit positions in 7ffd, eff7 and xxBF
package zport_cfg_pkg;

	// reset values
	localparam logic [7:0] p7ffd_rst = 8'h00; // rom bit included, no rom select
	localparam logic [7:0] peff7_rst = 8'h00;
	localparam logic [7:0] bf_rst    = 8'h00;

	////////////////////////////////////////////////////////////////////////////
	// 7ffd

	localparam int b7ffd_pg_hi  = 2; // 128k page in bits 2:0
	localparam int b7ffd_rom    = 4; // rom select
	localparam int b7ffd_blk48  = 5; // 48k lock
	localparam int b7ffd_hpg_lo = 5; // pentagon high page, bits 7:5
	localparam int b7ffd_hpg_hi = 7;

	////////////////////////////////////////////////////////////////////////////
	// eff7

	localparam int beff7_blk1m = 2; // 1m lock, also turns the 1m paging off
	localparam int beff7_ram0  = 3; // ram in place of rom at 0000

	////////////////////////////////////////////////////////////////////////////
	// xxBF

	localparam int bbf_shadow = 0; // shadow ports enable
	localparam int bbf_romrw  = 1; // rom write enable
	localparam int bbf_nmi    = 3; // nmi request

endpackage

//--- verilog/zbus_strobe.sv
// z80 i/o strobe generator
// one-clock port write and read strobes on zclk from iorq_n/rd_n/wr_n
module zbus_strobe
(
	input  logic zclk,
	input  logic rst_n,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	output logic port_wr, // one clock per write cycle
	output logic port_rd, // one clock per read cycle
	output logic iord     // read cycle active, combinational
);

	logic iowr;      // write cycle active
	logic iowr_prev; // level at the previous edge
	logic iord_prev;

	// raw bus levels
	assign iowr = ~(iorq_n | wr_n);
	assign iord = ~(iorq_n | rd_n);

	// strobe on the first edge that sees the cycle
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			iowr_prev <= 1'b1; // a cycle held over reset gives no strobe
			iord_prev <= 1'b1;
			port_wr   <= 1'b0;
			port_rd   <= 1'b0;
		end
		else
		begin
			iowr_prev <= iowr;
			iord_prev <= iord;
			port_wr   <= iowr & ~iowr_prev; // rising edge of the write level
			port_rd   <= iord & ~iord_prev;
		end
	end

endmodule

//--- verilog/port_decode.sv
// port address decoder
// per-port selects and porthit from the address and shadow mode
module port_decode
(
	input  zport_map_pkg::zaddr_u a,
	input  logic                  shadow,   // dos or shadow_en
	output logic                  porthit,  // any internal port
	output logic                  sel_fe,
	output logic                  sel_7ffd,
	output logic                  sel_eff7,
	output logic                  sel_bf,
	output logic                  sel_be,
	output logic                  sel_kjoy,
	output logic                  sel_sav
);

	import zport_map_pkg::*;

	logic [7:0] lo;
	logic       sav_hit; // one of the four save port numbers

	assign lo = a.bytes.lo;

	////////////////////////////////////////////////////////////////////////////
	// address compares

	always_comb
	begin
		sav_hit = (lo == port_sav1) || (lo == port_sav2) ||
		          (lo == port_sav3) || (lo == port_sav4);

		sel_fe   = (lo == port_fe);                   // any xxFE
		sel_7ffd = (lo == port_fd) && !a.sel.a15;     // 7ffd and its mirrors
		sel_bf   = (lo == port_bf);
		sel_be   = (lo == port_be);

		// eff7 sits at a8=1 normally and at a8=0 in shadow,
		// away from the xFF7 ports used there
		sel_eff7 = (lo == port_f7) && !a.sel.a12 &&
		           (a.sel.be_idx[0] != shadow);

		// joystick shares 1F with the fdc, so only out of shadow
		sel_kjoy = (lo == port_kjoy) && !shadow;

		// save ports live only in shadow
		sel_sav  = sav_hit && shadow;
	end

	// internal port hit
	assign porthit = sel_fe | sel_7ffd | sel_eff7 | sel_bf |
	                 sel_be | sel_kjoy | sel_sav;

endmodule

//--- verilog/mem_pager.sv
// memory paging registers
// 7ffd and eff7 with the 48k and 1m locks, and the pentagon 1m outputs
module mem_pager
(
	input  logic       zclk,
	input  logic       rst_n,
	input  logic       port_wr,        // one-clock write strobe
	input  logic       sel_7ffd,
	input  logic       sel_eff7,
	input  logic [7:0] din,
	output logic [7:0] p7ffd_raw,      // unmasked, for read-back
	output logic [7:0] peff7_raw,
	output logic [7:0] p7ffd,          // masked by the 1m lock
	output logic [7:0] peff7,
	output logic [5:0] pent1m_page,    // full 1m page number
	output logic       pent1m_rom,
	output logic       pent1m_1m_on,
	output logic       pent1m_ram0_0
);

	import zport_cfg_pkg::*;

	logic block1m;   // eff7 lock bit
	logic block7ffd; // 7ffd frozen

	assign block1m   = peff7_raw[beff7_blk1m];
	assign block7ffd = p7ffd_raw[b7ffd_blk48] & block1m; // 48k lock only holds with 1m lock

	////////////////////////////////////////////////////////////////////////////
	// registers

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			p7ffd_raw <= p7ffd_rst;
			peff7_raw <= peff7_rst;
		end
		else
		begin
			// 2..0 page, 3 screen, 4 rom, 5 lock48, 7..6 high page
			if (port_wr && sel_7ffd && !block7ffd)
				p7ffd_raw <= din;
			if (port_wr && sel_eff7)
				peff7_raw <= din; // 0 p16c, 2 lock1m, 3 ram0, 4 turbo off
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// paging outputs

	// high page bits gone under the 1m lock
	assign p7ffd = {(block1m ? 3'b000 : p7ffd_raw[b7ffd_hpg_hi:b7ffd_hpg_lo]),
	                p7ffd_raw[b7ffd_hpg_lo-1:0]};

	// locked eff7 keeps only bits 7, 5, 4 and 0
	assign peff7 = block1m ? {peff7_raw[7], 1'b0, peff7_raw[5], peff7_raw[4],
	                          3'b000, peff7_raw[0]}
	                       : peff7_raw;

	assign pent1m_page   = {p7ffd_raw[b7ffd_hpg_hi:b7ffd_hpg_lo],
	                        p7ffd_raw[b7ffd_pg_hi:0]};
	assign pent1m_rom    = p7ffd_raw[b7ffd_rom];
	assign pent1m_1m_on  = ~block1m;                   // 1m paging on until locked
	assign pent1m_ram0_0 = peff7_raw[beff7_ram0];

endmodule

//--- verilog/evo_config.sv
// evo config ports
// xxBF config, xxFE border, the four save ports and the clear-nmi pulse
module evo_config
(
	input  logic                  zclk,
	input  logic                  rst_n,
	input  logic                  port_wr,
	input  logic                  dos,      // dos rom active
	input  logic                  sel_fe,
	input  logic                  sel_bf,
	input  logic                  sel_be,
	input  logic                  sel_sav,
	input  zport_map_pkg::zaddr_u a,
	input  logic [7:0]            din,
	output logic                  shadow,   // shadow port map on
	output logic                  romrw_en,
	output logic                  set_nmi,
	output logic                  clr_nmi,  // one clock, with port_wr
	output logic [3:0]            border,
	output logic [7:0]            sav_data  // save port picked by a[6:5]
);

	import zport_map_pkg::*;
	import zport_cfg_pkg::*;

	logic       shadow_en;                  // bf bit 0
	logic [7:0] sav_mem [2**sav_idx_w];     // save ports 2F/4F/6F/8F

	////////////////////////////////////////////////////////////////////////////
	// port writes

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			shadow_en <= bf_rst[bbf_shadow];
			romrw_en  <= bf_rst[bbf_romrw];
			set_nmi   <= bf_rst[bbf_nmi];
			border    <= 4'h0;
			for (int i = 0; i < 2**sav_idx_w; i++)
				sav_mem[i] <= 8'h00;
		end
		else
		begin
			if (port_wr && sel_bf)
			begin
				shadow_en <= din[bbf_shadow];
				romrw_en  <= din[bbf_romrw];
				set_nmi   <= din[bbf_nmi];
			end
			if (port_wr && sel_fe)
				border <= {din[7], din[2:0]}; // bright bit plus colour
			if (port_wr && sel_sav)
				sav_mem[a.sel.sav_idx] <= din;
		end
	end

	assign shadow   = dos | shadow_en;
	assign clr_nmi  = port_wr & sel_be;         // any write to xxBE ends nmi
	assign sav_data = sav_mem[a.sel.sav_idx];

endmodule

//--- verilog/read_mux.sv
// read-data mux of the i/o block
// picks dout from the port selects and drives dataout on a port hit
module read_mux
(
	input  zport_map_pkg::zaddr_u a,
	input  logic                  iord,      // read cycle active
	input  logic                  porthit,
	input  logic                  sel_fe,
	input  logic                  sel_kjoy,
	input  logic                  sel_sav,
	input  logic                  sel_bf,
	input  logic                  sel_be,
	input  logic [4:0]            keys_in,   // keyboard half-row
	input  logic                  tape_read,
	input  logic [4:0]            kj_in,     // joystick
	input  logic [7:0]            sav_data,
	input  logic                  set_nmi,
	input  logic                  romrw_en,
	input  logic                  shadow,
	input  logic [7:0]            p7ffd_raw,
	input  logic [7:0]            peff7_raw,
	output logic [7:0]            dout,
	output logic                  dataout    // drive the z80 bus
);

	import zport_map_pkg::*;
	import zport_cfg_pkg::*;

	logic [7:0] bf_rd; // xxBF read value
	logic [7:0] be_rd; // xxBE read-back

	always_comb
	begin
		bf_rd             = 8'h00;
		bf_rd[bbf_nmi]    = set_nmi;
		bf_rd[bbf_romrw]  = romrw_en;
		bf_rd[bbf_shadow] = shadow; // effective shadow, dos included
	end

	// read-back index in a[11:8]
	always_comb
	begin
		case (a.sel.be_idx)
			be_idx_7ffd: be_rd = p7ffd_raw;
			be_idx_eff7: be_rd = peff7_raw;
			default:     be_rd = 8'hFF;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// output mux, selects are one-hot

	always_comb
	begin
		if (sel_fe)
			dout = {1'b1, tape_read, 1'b0, keys_in};
		else if (sel_kjoy)
			dout = {3'b000, kj_in};
		else if (sel_sav)
			dout = sav_data;
		else if (sel_bf)
			dout = bf_rd;
		else if (sel_be)
			dout = be_rd;
		else
			dout = 8'hFF; // floating bus
	end

	assign dataout = porthit & iord;

endmodule

//--- verilog/zports_top.sv
// z80 i/o port block, top level
// strobes, decode, paging, config and read mux wired together
module zports_top
(
	input  logic                  zclk,
	input  logic                  rst_n,
	input  zport_map_pkg::zaddr_u a,
	input  logic [7:0]            din,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic                  dos,
	input  logic [4:0]            keys_in,
	input  logic                  tape_read,
	input  logic [4:0]            kj_in,
	output logic [7:0]            dout,
	output logic                  dataout,
	output logic                  porthit,
	output logic [3:0]            border,
	output logic [7:0]            p7ffd,
	output logic [7:0]            peff7,
	output logic [5:0]            pent1m_page,
	output logic                  pent1m_rom,
	output logic                  pent1m_1m_on,
	output logic                  pent1m_ram0_0,
	output logic                  romrw_en,
	output logic                  set_nmi,
	output logic                  clr_nmi
);

	logic       port_wr, port_rd, iord;     // bus strobes
	logic       shadow;
	logic       sel_fe, sel_7ffd, sel_eff7, sel_bf;
	logic       sel_be, sel_kjoy, sel_sav;
	logic [7:0] p7ffd_raw, peff7_raw;       // read-back
	logic [7:0] sav_data;

	zbus_strobe u_strobe (.zclk, .rst_n, .iorq_n, .rd_n, .wr_n,
		.port_wr, .port_rd, .iord);

	port_decode u_decode (.a, .shadow, .porthit, .sel_fe, .sel_7ffd,
		.sel_eff7, .sel_bf, .sel_be, .sel_kjoy, .sel_sav);

	mem_pager u_pager (.zclk, .rst_n, .port_wr, .sel_7ffd, .sel_eff7, .din,
		.p7ffd_raw, .peff7_raw, .p7ffd, .peff7, .pent1m_page, .pent1m_rom,
		.pent1m_1m_on, .pent1m_ram0_0);

	evo_config u_config (.zclk, .rst_n, .port_wr, .dos, .sel_fe, .sel_bf,
		.sel_be, .sel_sav, .a, .din, .shadow, .romrw_en, .set_nmi, .clr_nmi,
		.border, .sav_data);

	read_mux u_rdmux (.a, .iord, .porthit, .sel_fe, .sel_kjoy, .sel_sav,
		.sel_bf, .sel_be, .keys_in, .tape_read, .kj_in, .sav_data, .set_nmi,
		.romrw_en, .shadow, .p7ffd_raw, .peff7_raw, .dout, .dataout);

endmodule

//--- verif/zports_sva.sv
// strobe and 48k lock assertions
// bound into zbus_strobe and mem_pager
module zports_sva
(
	input logic       zclk,
	input logic       rst_n,
	input logic       wr_stb,
	input logic       rd_stb,
	input logic [7:0] p7ffd_raw,
	input logic [7:0] peff7_raw
);

	import zport_cfg_pkg::*;

	logic block7ffd; // 48k lock together with 1m lock

	assign block7ffd = p7ffd_raw[b7ffd_blk48] & peff7_raw[beff7_blk1m];

	// one clock per bus cycle, never two in a row
	a_wr_single : assert property (@(posedge zclk) disable iff (!rst_n) wr_stb |=> !wr_stb)
		else $error("port_wr high on two clocks running");
	a_rd_single : assert property (@(posedge zclk) disable iff (!rst_n) rd_stb |=> !rd_stb)
		else $error("port_rd high on two clocks running");

	// frozen 7ffd
	a_lock : assert property (@(posedge zclk) disable iff (!rst_n)
		block7ffd |=> $stable(p7ffd_raw))
		else $error("7ffd changed under the 48k lock");

endmodule

bind zbus_strobe zports_sva sva_strobe (.zclk(zclk), .rst_n(rst_n), .wr_stb(port_wr),
	.rd_stb(port_rd), .p7ffd_raw(8'h00), .peff7_raw(8'h00));

bind mem_pager zports_sva sva_pager (.zclk(zclk), .rst_n(rst_n), .wr_stb(port_wr),
	.rd_stb(1'b0), .p7ffd_raw(p7ffd_raw), .peff7_raw(peff7_raw));

//--- verif/zports_checker.sv
// reference model of the port block
// follows each bus cycle, compares dut outputs on the falling edge
module zports_checker
(
	input logic                  zclk,
	input logic                  rst_n,
	input zport_map_pkg::zaddr_u a,
	input logic [7:0]            din, dout, p7ffd, peff7,
	input logic                  iorq_n, rd_n, wr_n, dos, tape_read,
	input logic [4:0]            keys_in, kj_in,
	input logic                  dataout, porthit, pent1m_rom, pent1m_1m_on,
	input logic                  pent1m_ram0_0, romrw_en, set_nmi, clr_nmi,
	input logic [3:0]            border,
	input logic [5:0]            pent1m_page
);

	import zport_map_pkg::*;

	int         errors = 0;
	int         checks = 0;
	logic [7:0] m7ffd, meff7;       // raw paging model
	logic [7:0] msav [4];
	logic       mshadow_en, mromrw, mnmi;
	logic [3:0] mborder;
	logic [6:0] hit;                // fe 7ffd eff7 bf be kjoy sav
	logic [7:0] exp_rd;
	logic       be_wr;              // this cycle writes xxBE
	logic       lock1m;
	int         k;                  // falling edges into the cycle

	// port hits straight from the port map rules
	function automatic logic [6:0] decode(logic [15:0] ad, logic sh);
		logic [7:0] lo;
		lo = ad[7:0];
		return {lo == port_fe, lo == port_fd && !ad[15],
		        lo == port_f7 && !ad[12] && (ad[8] == !sh), // a8 flips in shadow
		        lo == port_bf, lo == port_be, lo == port_kjoy && !sh,
		        sh && (lo == port_sav1 || lo == port_sav2 ||
		               lo == port_sav3 || lo == port_sav4)};
	endfunction

	task automatic check(string what, logic [7:0] got, logic [7:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	always @(negedge zclk)
	begin
		if (!rst_n)
		begin
			m7ffd      = 8'h00;
			meff7      = 8'h00;
			mshadow_en = 1'b0;
			mromrw     = 1'b0;
			mnmi       = 1'b0;
			mborder    = 4'h0;
			for (int i = 0; i < 4; i++)
				msav[i] = 8'h00;
			be_wr = 1'b0;
			k     = 0;
		end
		else if (!iorq_n)
		begin
			hit = decode(a, dos | mshadow_en);
			if (!wr_n && k == 0)      // write lands once per cycle
			begin
				if (hit[5] && !(m7ffd[5] && meff7[2]))
					m7ffd = din;
				if (hit[4])
					meff7 = din;
				if (hit[3])
				begin
					mshadow_en = din[0];
					mromrw     = din[1];
					mnmi       = din[3];
				end
				if (hit[6])
					mborder = {din[7], din[2:0]};
				if (hit[0])
					msav[a.sel.sav_idx] = din;
				be_wr = hit[2];
			end
			if (!rd_n)
			begin
				exp_rd = 8'hFF;   // unmapped
				if (hit[6])
					exp_rd = {1'b1, tape_read, 1'b0, keys_in};
				if (hit[1])
					exp_rd = {3'b000, kj_in};
				if (hit[0])
					exp_rd = msav[a.sel.sav_idx];
				if (hit[3])
					exp_rd = {4'h0, mnmi, 1'b0, mromrw, dos | mshadow_en};
				if (hit[2])
					exp_rd = (a.sel.be_idx == 4'hA) ? m7ffd :
					         (a.sel.be_idx == 4'hB) ? meff7 : 8'hFF;
				check("dout", dout, exp_rd);
				check("dataout porthit", 8'({dataout, porthit}), 8'({|hit, |hit}));
			end
			check("clr_nmi", 8'(clr_nmi), 8'(k == 1 && be_wr)); // strobe clock only
			k++;
		end
		else
		begin
			k      = 0;
			be_wr  = 1'b0;
			lock1m = meff7[2];
			check("border", 8'(border), 8'(mborder));
			check("p7ffd", p7ffd, lock1m ? {3'b000, m7ffd[4:0]} : m7ffd);
			check("peff7", peff7, lock1m ? (meff7 & 8'hB1) : meff7); // 7 5 4 0 kept
			check("pent1m_page", 8'(pent1m_page), 8'({m7ffd[7:5], m7ffd[2:0]}));
			check("pent1m flags", 8'({pent1m_rom, pent1m_1m_on, pent1m_ram0_0}),
			      8'({m7ffd[4], !lock1m, meff7[3]}));
			check("config", 8'({romrw_en, set_nmi, clr_nmi, dataout}),
			      8'({mromrw, mnmi, 2'b00}));
		end
	end

endmodule

//--- verif/tb_zports.sv
// testbench of the z80 port block
// lfsr-driven bus cycles, compared by zports_checker
module tb_zports;

	import zport_map_pkg::*;

	localparam logic [31:0] lfsr_seed    = 32'd75199;
	localparam logic [31:0] lfsr_taps    = 32'h80200003; // x^32+x^22+x^2+x+1
	localparam int          timeout_clks = 64;

	logic        zclk, rst_n, iorq_n, rd_n, wr_n, dos, tape_read;
	zaddr_u      a;
	logic [7:0]  din, dout, p7ffd, peff7;
	logic [4:0]  keys_in, kj_in;
	logic        dataout, porthit, pent1m_rom, pent1m_1m_on, pent1m_ram0_0;
	logic        romrw_en, set_nmi, clr_nmi;
	logic [3:0]  border;
	logic [5:0]  pent1m_page;
	logic [31:0] lfsr;
	logic        timed_out;
	logic [7:0]  r, r2;
	int          tests_run, tests_bad, err_mark;

	zports_top     dut (.*);
	zports_checker chk (.*);

	initial
	begin
		zclk = 1'b0;
		forever #2 zclk = ~zclk;
	end

	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
	endfunction

	// n fresh bits, one step each
	function automatic logic [7:0] rnd(int n);
		logic [7:0] v;
		v = 8'h00;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v    = {v[6:0], lfsr[0]};
		end
		return v;
	endfunction

	// one i/o cycle held 2..4 clocks, then back to idle
	task automatic bus_cycle(logic wr, logic [15:0] addr, logic [7:0] data);
		int hold;
		int n;
		if (timed_out)
			return;
		hold   = 2 + int'(rnd(2)) % 3;
		a      = addr;
		din    = data;
		wr_n   = !wr;
		rd_n   = wr;
		iorq_n = 1'b0;
		for (n = 0; n < hold; n++)
			@(posedge zclk);
		#1;
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		rd_n   = 1'b1;
		n      = 0;
		while ((dataout || dut.u_strobe.port_wr || dut.u_strobe.port_rd) &&
		       n < timeout_clks)
		begin
			@(posedge zclk);
			#1;
			n++;
		end
		if (n >= timeout_clks)
		begin
			$display("timeout: bus did not go idle after port %h", addr);
			timed_out = 1'b1;
		end
		@(posedge zclk); // idle clock between cycles
		#1;
	endtask

	task automatic end_test(string name);
		tests_run++;
		if (timed_out || chk.errors != err_mark)
		begin
			tests_bad++;
			$display("test %0d %s: FAIL, %0d errors", tests_run, name, chk.errors - err_mark);
		end
		else
			$display("test %0d %s: ok", tests_run, name);
		err_mark = chk.errors;
	endtask

	initial
	begin
		lfsr      = lfsr_seed;
		timed_out = 1'b0;
		tests_run = 0;
		tests_bad = 0;
		err_mark  = 0;
		rst_n     = 1'b0;
		a         = 16'h0000;
		din       = 8'h00;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		dos       = 1'b0;
		keys_in   = 5'h1F;  // no key down
		tape_read = 1'b0;
		kj_in     = 5'h00;
		repeat (8) @(posedge zclk);
		#1;
		rst_n = 1'b1;
		@(posedge zclk);
		#1;

		// reset state, config and read-back ports
		bus_cycle(0, {8'h00, port_bf}, 8'h00);
		bus_cycle(0, 16'h0ABE, 8'h00);
		bus_cycle(0, 16'h0BBE, 8'h00);
		end_test("reset");

		repeat (12)
		begin
			r         = rnd(8);
			keys_in   = r[4:0];
			tape_read = r[5];
			bus_cycle(1, {rnd(8), port_fe}, rnd(8));
			bus_cycle(0, {rnd(8), port_fe}, 8'h00);
		end
		end_test("border");

		// random high byte, so a15, a12 and a8 all vary
		repeat (40)
		begin
			r = rnd(8);
			bus_cycle(1, {rnd(8), r[0] ? port_fd : port_f7}, rnd(8));
			bus_cycle(0, {4'h0, r[1] ? 4'hA : 4'hB, port_be}, 8'h00);
		end
		bus_cycle(1, 16'h01F7, 8'h04); // 1m lock
		bus_cycle(1, 16'h7FFD, 8'h20); // 48k lock
		bus_cycle(1, 16'h7FFD, rnd(8)); // blocked
		bus_cycle(0, 16'h0ABE, 8'h00);
		bus_cycle(1, 16'h01F7, 8'h00);
		end_test("paging");

		// shadow from dos, then from the bf bit, then off
		for (int s = 2; s >= 0; s--)
		begin
			dos = s[1];
			repeat (6)
			begin
				r = rnd(8);
				bus_cycle(1, {rnd(8), port_bf}, {r[7:1], s[0]}); // shadow_en fixed per pass
				bus_cycle(0, {rnd(8), port_bf}, 8'h00);
				r  = rnd(8);
				r2 = (r[3:2] == 2'd0) ? port_sav1 : (r[3:2] == 2'd1) ? port_sav2 :
				     (r[3:2] == 2'd2) ? port_sav3 : port_sav4;
				bus_cycle(1, {7'h00, r[1], port_f7}, rnd(8)); // a8 picks the eff7 site
				bus_cycle(1, {rnd(8), r2}, rnd(8));
				bus_cycle(0, {rnd(8), r2}, 8'h00);
				kj_in = r[7:3];
				bus_cycle(0, {rnd(8), port_kjoy}, 8'h00);
			end
		end
		end_test("shadow");

		repeat (16)
		begin
			r = rnd(8);
			bus_cycle(1, {rnd(8), port_be}, rnd(8));
			bus_cycle(0, {4'h0, r[4] ? {3'b101, r[0]} : r[3:0], port_be}, 8'h00);
		end
		end_test("nmi and read-back");

		repeat (24)
		begin
			r = rnd(8);
			if (!(r inside {port_fe, port_fd, port_f7, port_bf, port_be, port_kjoy,
			                port_sav1, port_sav2, port_sav3, port_sav4}))
				bus_cycle(0, {rnd(8), r}, 8'h00);
		end
		end_test("unmapped");

		$display("%0d tests run, %0d with errors, %0d checks, %0d mismatches",
		         tests_run, tests_bad, chk.checks, chk.errors);
		if (tests_bad == 0 && !timed_out)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- zports_top.f
verilog/zport_map_pkg.sv
verilog/zport_cfg_pkg.sv
verilog/zbus_strobe.sv
verilog/port_decode.sv
verilog/mem_pager.sv
verilog/evo_config.sv
verilog/read_mux.sv
verilog/zports_top.sv
verif/zports_sva.sv
verif/zports_checker.sv
verif/tb_zports.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the port block testbench with verilator and runs it
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal -f zports_top.f \
	--top-module tb_zports -Mdir obj_dir -o sim_zports
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_zports > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "tests failed" "$log"; then
	echo "FAIL"
	exit 1
fi
if ! grep -q "all tests passed" "$log"; then
	echo "no result line in $log"
	exit 1
fi
echo "PASS"
